/* include/wb_cfg.svh */
// ====================
// wb config: bus widths and response timeout
// for the two-master connection matrix.
// ====================

`ifndef WB_CFG_SVH
`define WB_CFG_SVH

// address bus width.
`define WB_ADR_W 16

// data bus width.
`define WB_DAT_W 32

// waiting cycles before a strobe ends with err.
`define WB_TIMEOUT 16

`endif

/* design/wb_pkg.sv */
// ====================
// wb package: arbiter states, slave select
// and cycle response types.
// ====================

package wb_pkg;

   // owner of the shared bus.
   typedef enum logic [1:0] {
      ARB_IDLE   = 2'b00,
      ARB_GRANT0 = 2'b01,
      ARB_GRANT1 = 2'b10
   } arb_state_e;

   // address decode result.
   typedef enum logic [1:0] {
      SEL_S0   = 2'b00,
      SEL_S1   = 2'b01,
      SEL_NONE = 2'b10
   } slave_sel_e;

   // outcome of one bus cycle.
   typedef enum logic {
      RESP_OK  = 1'b0,
      RESP_ERR = 1'b1
   } wb_resp_e;

   // upper address bits to slave select; 1x is unmapped.
   function automatic slave_sel_e wb_decode(input logic [1:0] region);
      case (region)
         2'b00:   return SEL_S0;
         2'b01:   return SEL_S1;
         default: return SEL_NONE;
      endcase
   endfunction

endpackage : wb_pkg

/* design/wb_bus_if.sv */
// ====================
// wb bus interface: one wishbone bus with
// master and slave views.
// ====================

`include "wb_cfg.svh"

interface wb_bus_if;

   logic                 cyc;    // bus cycle in progress.
   logic                 stb;    // transfer strobe.
   logic                 we;     // write enable.
   logic [`WB_ADR_W-1:0] adr;    // byte address.
   logic [`WB_DAT_W-1:0] dat_w;  // master to slave data.
   logic [`WB_DAT_W-1:0] dat_r;  // slave to master data.
   logic                 ack;    // normal termination.
   logic                 err;    // error termination.

   // drives the request, samples the response.
   modport master (
      output cyc,
      output stb,
      output we,
      output adr,
      output dat_w,
      input  dat_r,
      input  ack,
      input  err
   );

   // mirror of the master view.
   modport slave (
      input  cyc,
      input  stb,
      input  we,
      input  adr,
      input  dat_w,
      output dat_r,
      output ack,
      output err
   );

endinterface : wb_bus_if

/* design/wb_arbiter_fsm.sv */
// ====================
// wb arbiter: round-robin grant of the shared
// bus between two masters, registered grant.
// ====================

module wb_arbiter_fsm (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                m0_cyc,
   input  logic                m1_cyc,
   output wb_pkg::arb_state_e  state
);

   import wb_pkg::*;

   arb_state_e state_next;
   logic       last_m1;       // set when master 1 was served last.

   always_comb begin
      state_next = state;
      case (state)
         ARB_IDLE: begin
            if (m0_cyc && m1_cyc) begin
               state_next = last_m1 ? ARB_GRANT0 : ARB_GRANT1;
            end else if (m0_cyc) begin
               state_next = ARB_GRANT0;
            end else if (m1_cyc) begin
               state_next = ARB_GRANT1;
            end
         end
         ARB_GRANT0: begin
            if (!m0_cyc) begin
               state_next = ARB_IDLE;  // release on the next edge.
            end
         end
         ARB_GRANT1: begin
            if (!m1_cyc) begin
               state_next = ARB_IDLE;
            end
         end
         default: state_next = ARB_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= ARB_IDLE;
         last_m1 <= 1'b0;          // master 0 counts as served last.
      end else begin
         state <= state_next;
         if (state == ARB_IDLE && state_next == ARB_GRANT0) begin
            last_m1 <= 1'b0;
         end else if (state == ARB_IDLE && state_next == ARB_GRANT1) begin
            last_m1 <= 1'b1;
         end
      end
   end

endmodule : wb_arbiter_fsm

/* design/wb_ack_timer.sv */
// ====================
// wb ack timer: counts unanswered strobe cycles
// and flags expiry at the timeout limit.
// ====================

`include "wb_cfg.svh"

module wb_ack_timer (
   input  logic clk,
   input  logic rst_n,
   input  logic stb,
   input  logic ack,
   input  logic err,
   output logic expire
);

   localparam int CNT_W = $clog2(`WB_TIMEOUT + 1);
   localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`WB_TIMEOUT);

   logic [CNT_W-1:0] wait_cnt;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wait_cnt <= '0;
      end else if (!stb || ack || err) begin
         wait_cnt <= '0;               // idle or answered.
      end else if (wait_cnt != CNT_MAX) begin
         wait_cnt <= wait_cnt + 1'b1;  // saturates at the limit.
      end
   end

   assign expire = (wait_cnt == CNT_MAX);

   // the master must still be strobing when the limit is hit.
   a_expire_stb: assert property (@(posedge clk) disable iff (!rst_n)
      expire |-> stb)
      else $error("timer expired without an active strobe");

endmodule : wb_ack_timer

/* design/wb_master_mux.sv */
// ====================
// wb master mux: granted master's request onto
// the shared bus, response back to it only.
// ====================

`include "wb_cfg.svh"

module wb_master_mux (
   input  wb_pkg::arb_state_e    state,
   input  logic                  m0_cyc,
   input  logic                  m0_stb,
   input  logic                  m0_we,
   input  logic [`WB_ADR_W-1:0]  m0_adr,
   input  logic [`WB_DAT_W-1:0]  m0_dat_w,
   output logic [`WB_DAT_W-1:0]  m0_dat_r,
   output logic                  m0_ack,
   output logic                  m0_err,
   input  logic                  m1_cyc,
   input  logic                  m1_stb,
   input  logic                  m1_we,
   input  logic [`WB_ADR_W-1:0]  m1_adr,
   input  logic [`WB_DAT_W-1:0]  m1_dat_w,
   output logic [`WB_DAT_W-1:0]  m1_dat_r,
   output logic                  m1_ack,
   output logic                  m1_err,
   wb_bus_if.master              bus
);

   import wb_pkg::*;

   always_comb begin
      bus.cyc   = 1'b0;
      bus.stb   = 1'b0;
      bus.we    = 1'b0;
      bus.adr   = '0;
      bus.dat_w = '0;
      m0_dat_r  = '0;
      m0_ack    = 1'b0;
      m0_err    = 1'b0;
      m1_dat_r  = '0;
      m1_ack    = 1'b0;
      m1_err    = 1'b0;
      case (state)
         ARB_GRANT0: begin
            bus.cyc   = m0_cyc;
            bus.stb   = m0_stb;
            bus.we    = m0_we;
            bus.adr   = m0_adr;
            bus.dat_w = m0_dat_w;
            m0_dat_r  = bus.dat_r;
            m0_ack    = bus.ack;
            m0_err    = bus.err;
         end
         ARB_GRANT1: begin
            bus.cyc   = m1_cyc;
            bus.stb   = m1_stb;
            bus.we    = m1_we;
            bus.adr   = m1_adr;
            bus.dat_w = m1_dat_w;
            m1_dat_r  = bus.dat_r;
            m1_ack    = bus.ack;
            m1_err    = bus.err;
         end
         default: ;  // idle bus, both masters wait.
      endcase
   end

endmodule : wb_master_mux

/* design/wb_slave_decoder.sv */
// ====================
// wb slave decoder: address decode to one slave,
// response mux with decode and timeout errors.
// ====================

`include "wb_cfg.svh"

module wb_slave_decoder (
   wb_bus_if.slave               bus,
   input  logic                  expire,
   output logic                  s0_cyc,
   output logic                  s0_stb,
   output logic                  s0_we,
   output logic [`WB_ADR_W-1:0]  s0_adr,
   output logic [`WB_DAT_W-1:0]  s0_dat_w,
   input  logic [`WB_DAT_W-1:0]  s0_dat_r,
   input  logic                  s0_ack,
   input  logic                  s0_err,
   output logic                  s1_cyc,
   output logic                  s1_stb,
   output logic                  s1_we,
   output logic [`WB_ADR_W-1:0]  s1_adr,
   output logic [`WB_DAT_W-1:0]  s1_dat_w,
   input  logic [`WB_DAT_W-1:0]  s1_dat_r,
   input  logic                  s1_ack,
   input  logic                  s1_err
);

   import wb_pkg::*;

   slave_sel_e sel;
   wb_resp_e   resp;
   logic       slv_ack;
   logic       slv_err;
   logic       resp_vld;

   assign sel = wb_decode(bus.adr[`WB_ADR_W-1 -: 2]);

   // request side, strobe only the decoded slave.
   always_comb begin
      s0_cyc = bus.cyc && (sel == SEL_S0);
      s0_stb = bus.stb && (sel == SEL_S0);
      s1_cyc = bus.cyc && (sel == SEL_S1);
      s1_stb = bus.stb && (sel == SEL_S1);
   end

   assign s0_we    = bus.we;
   assign s0_adr   = bus.adr;
   assign s0_dat_w = bus.dat_w;
   assign s1_we    = bus.we;
   assign s1_adr   = bus.adr;
   assign s1_dat_w = bus.dat_w;

   always_comb begin
      case (sel)
         SEL_S0: begin
            bus.dat_r = s0_dat_r;
            slv_ack   = s0_ack;
            slv_err   = s0_err;
         end
         SEL_S1: begin
            bus.dat_r = s1_dat_r;
            slv_ack   = s1_ack;
            slv_err   = s1_err;
         end
         default: begin
            bus.dat_r = '0;
            slv_ack   = 1'b0;
            slv_err   = bus.stb;  // unmapped, error at once.
         end
      endcase
   end

   // a timeout overrides a late ack in the same cycle.
   assign resp_vld = slv_ack || slv_err || expire;
   assign resp     = (slv_err || expire) ? RESP_ERR : RESP_OK;
   assign bus.ack  = resp_vld && (resp == RESP_OK);
   assign bus.err  = resp_vld && (resp == RESP_ERR);

endmodule : wb_slave_decoder

/* design/wb_conmax_lite.sv */
// ====================
// wb conmax lite: two masters share one bus
// to two slaves, with timeout errors.
// ====================

`include "wb_cfg.svh"

module wb_conmax_lite (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  m0_cyc,
   input  logic                  m0_stb,
   input  logic                  m0_we,
   input  logic [`WB_ADR_W-1:0]  m0_adr,
   input  logic [`WB_DAT_W-1:0]  m0_dat_w,
   output logic [`WB_DAT_W-1:0]  m0_dat_r,
   output logic                  m0_ack,
   output logic                  m0_err,
   input  logic                  m1_cyc,
   input  logic                  m1_stb,
   input  logic                  m1_we,
   input  logic [`WB_ADR_W-1:0]  m1_adr,
   input  logic [`WB_DAT_W-1:0]  m1_dat_w,
   output logic [`WB_DAT_W-1:0]  m1_dat_r,
   output logic                  m1_ack,
   output logic                  m1_err,
   output logic                  s0_cyc,
   output logic                  s0_stb,
   output logic                  s0_we,
   output logic [`WB_ADR_W-1:0]  s0_adr,
   output logic [`WB_DAT_W-1:0]  s0_dat_w,
   input  logic [`WB_DAT_W-1:0]  s0_dat_r,
   input  logic                  s0_ack,
   input  logic                  s0_err,
   output logic                  s1_cyc,
   output logic                  s1_stb,
   output logic                  s1_we,
   output logic [`WB_ADR_W-1:0]  s1_adr,
   output logic [`WB_DAT_W-1:0]  s1_dat_w,
   input  logic [`WB_DAT_W-1:0]  s1_dat_r,
   input  logic                  s1_ack,
   input  logic                  s1_err
);

   import wb_pkg::*;

   arb_state_e arb_state;  // current bus owner.
   logic       expire;     // selected slave timed out.

   wb_bus_if shared_bus ();

   wb_arbiter_fsm u_arbiter (
      .clk    (clk),
      .rst_n  (rst_n),
      .m0_cyc (m0_cyc),
      .m1_cyc (m1_cyc),
      .state  (arb_state)
   );

   // the timer sees the final response, including its own err.
   wb_ack_timer u_timer (
      .clk    (clk),
      .rst_n  (rst_n),
      .stb    (shared_bus.stb),
      .ack    (shared_bus.ack),
      .err    (shared_bus.err),
      .expire (expire)
   );

   wb_master_mux u_mmux (
      .state    (arb_state),
      .m0_cyc   (m0_cyc),
      .m0_stb   (m0_stb),
      .m0_we    (m0_we),
      .m0_adr   (m0_adr),
      .m0_dat_w (m0_dat_w),
      .m0_dat_r (m0_dat_r),
      .m0_ack   (m0_ack),
      .m0_err   (m0_err),
      .m1_cyc   (m1_cyc),
      .m1_stb   (m1_stb),
      .m1_we    (m1_we),
      .m1_adr   (m1_adr),
      .m1_dat_w (m1_dat_w),
      .m1_dat_r (m1_dat_r),
      .m1_ack   (m1_ack),
      .m1_err   (m1_err),
      .bus      (shared_bus.master)
   );

   wb_slave_decoder u_sdec (
      .bus      (shared_bus.slave),
      .expire   (expire),
      .s0_cyc   (s0_cyc),
      .s0_stb   (s0_stb),
      .s0_we    (s0_we),
      .s0_adr   (s0_adr),
      .s0_dat_w (s0_dat_w),
      .s0_dat_r (s0_dat_r),
      .s0_ack   (s0_ack),
      .s0_err   (s0_err),
      .s1_cyc   (s1_cyc),
      .s1_stb   (s1_stb),
      .s1_we    (s1_we),
      .s1_adr   (s1_adr),
      .s1_dat_w (s1_dat_w),
      .s1_dat_r (s1_dat_r),
      .s1_ack   (s1_ack),
      .s1_err   (s1_err)
   );

endmodule : wb_conmax_lite

/* dv/wb_conmax_tb_top.sv */
// ====================
// wb conmax lite testbench: two driven masters,
// two memory slave models, file driven checks.
// ====================

`include "wb_cfg.svh"

// memory slave with random wait states; optional dead word at 0xff.
module mem_slave #(parameter bit SILENT_FF = 1'b0) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 cyc,
   input  logic                 stb,
   input  logic                 we,
   input  logic [`WB_ADR_W-1:0] adr,
   input  logic [`WB_DAT_W-1:0] dat_w,
   output logic [`WB_DAT_W-1:0] dat_r,
   output logic                 ack
);
   timeunit 1ns;
   timeprecision 1ps;

   logic [`WB_DAT_W-1:0] mem [256];
   logic [31:0]          rng;
   logic [1:0]           wait_tgt;
   logic [1:0]           wait_cnt;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] v;
      v = x;
      v = v ^ (v << 13);
      v = v ^ (v >> 17);
      v = v ^ (v << 5);
      return v;
   endfunction

   initial begin
      for (int i = 0; i < 256; i++) begin
         mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'h3c};  // whole index in word.
      end
   end

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ack      <= 1'b0;
         dat_r    <= '0;
         wait_cnt <= '0;
         rng      <= xorshift32(32'd35);
         wait_tgt <= 2'(xorshift32(32'd35));
      end else if (ack) begin
         ack <= 1'b0;                     // one cycle pulse.
      end else if (cyc && stb && !(SILENT_FF && adr[7:0] == 8'hff)) begin
         if (wait_cnt == wait_tgt) begin
            ack      <= 1'b1;
            dat_r    <= mem[adr[7:0]];
            if (we) begin
               mem[adr[7:0]] <= dat_w;
            end
            rng      <= xorshift32(rng);
            wait_tgt <= 2'(xorshift32(rng)); // next wait, 0 to 3.
            wait_cnt <= '0;
         end else begin
            wait_cnt <= wait_cnt + 1'b1;
         end
      end else begin
         wait_cnt <= '0;
      end
   end
endmodule : mem_slave

module wb_conmax_tb_top;
   timeunit 1ns;
   timeprecision 1ps;

   import wb_pkg::*;

   logic clk;
   logic rst_n;
   logic                 m_cyc [2];
   logic                 m_stb [2];
   logic                 m_we [2];
   logic [`WB_ADR_W-1:0] m_adr [2];
   logic [`WB_DAT_W-1:0] m_dat_w [2];
   logic [`WB_DAT_W-1:0] m0_dat_r, m1_dat_r, s0_dat_r, s1_dat_r;
   logic                 m0_ack, m0_err, m1_ack, m1_err;
   logic                 s0_cyc, s0_stb, s0_we, s0_ack, s1_cyc, s1_stb, s1_we, s1_ack;
   logic [`WB_ADR_W-1:0] s0_adr, s1_adr;
   logic [`WB_DAT_W-1:0] s0_dat_w, s1_dat_w;

   string                t_name [$];
   int                   t_mst [$];
   int                   t_pair [$];
   int                   t_we [$];
   logic [`WB_ADR_W-1:0] t_adr [$];
   logic [`WB_DAT_W-1:0] t_wdat [$];
   wb_resp_e             t_resp [$];
   logic [`WB_DAT_W-1:0] t_rdat [$];
   wb_resp_e             got_resp [256];
   logic [`WB_DAT_W-1:0] got_data [256];
   int                   got_cyc [256];
   int                   order_q [$];
   int errors = 0;
   int tests = 0;
   int cyc_cnt = 0;
   int cyc_limit = 0;
   int last_served = 0;  // reset counts master 0 as served last.

   always #2 clk = ~clk;

   wb_conmax_lite dut (
      .clk (clk), .rst_n (rst_n),
      .m0_cyc (m_cyc[0]), .m0_stb (m_stb[0]), .m0_we (m_we[0]),
      .m0_adr (m_adr[0]), .m0_dat_w (m_dat_w[0]),
      .m0_dat_r (m0_dat_r), .m0_ack (m0_ack), .m0_err (m0_err),
      .m1_cyc (m_cyc[1]), .m1_stb (m_stb[1]), .m1_we (m_we[1]),
      .m1_adr (m_adr[1]), .m1_dat_w (m_dat_w[1]),
      .m1_dat_r (m1_dat_r), .m1_ack (m1_ack), .m1_err (m1_err),
      .s0_cyc (s0_cyc), .s0_stb (s0_stb), .s0_we (s0_we), .s0_adr (s0_adr),
      .s0_dat_w (s0_dat_w), .s0_dat_r (s0_dat_r), .s0_ack (s0_ack), .s0_err (1'b0),
      .s1_cyc (s1_cyc), .s1_stb (s1_stb), .s1_we (s1_we), .s1_adr (s1_adr),
      .s1_dat_w (s1_dat_w), .s1_dat_r (s1_dat_r), .s1_ack (s1_ack), .s1_err (1'b0)
   );

   mem_slave #(.SILENT_FF(1'b0)) u_slave0 (
      .clk (clk), .rst_n (rst_n), .cyc (s0_cyc), .stb (s0_stb), .we (s0_we),
      .adr (s0_adr), .dat_w (s0_dat_w), .dat_r (s0_dat_r), .ack (s0_ack)
   );

   mem_slave #(.SILENT_FF(1'b1)) u_slave1 (
      .clk (clk), .rst_n (rst_n), .cyc (s1_cyc), .stb (s1_stb), .we (s1_we),
      .adr (s1_adr), .dat_w (s1_dat_w), .dat_r (s1_dat_r), .ack (s1_ack)
   );

   // unmapped addresses must never reach a slave.
   always @(negedge clk) begin
      if (rst_n && (((s0_cyc || s0_stb) && s0_adr[15]) ||
                    ((s1_cyc || s1_stb) && s1_adr[15]))) begin
         $display("slave was selected for an unmapped address");
         errors++;
      end
   end

   // stops a run that no longer makes progress.
   initial begin
      wait (cyc_limit > 0);
      while (cyc_cnt < cyc_limit) begin
         @(posedge clk);
         cyc_cnt++;
      end
      $display("run hung: no bus response after %0d cycles", cyc_cnt);
      $display("TB FAILED");
      $finish;
   end

   task automatic check_resp(input string name, input wb_resp_e exp, input wb_resp_e act);
      if (exp !== act) begin
         $display("[ERROR] %s: expected %s, actual %s", name, exp.name(), act.name());
         errors++;
      end
   endtask

   task automatic check_data(input string name, input logic [`WB_DAT_W-1:0] exp,
                             input logic [`WB_DAT_W-1:0] act);
      if (exp !== act) begin
         $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_level(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_master(input string name, input int exp, input int act);
      if (exp != act) begin
         $display("[ERROR] %s: expected master %0d first, actual master %0d", name, exp, act);
         errors++;
      end
   endtask

   // one bus cycle from master idx; results land in the got_ arrays.
   task automatic run_txn(input int i);
      int idx;
      idx = t_mst[i];
      @(negedge clk);
      m_cyc[idx]   = 1'b1;
      m_stb[idx]   = 1'b1;
      m_we[idx]    = t_we[i][0];
      m_adr[idx]   = t_adr[i];
      m_dat_w[idx] = t_wdat[i];
      got_cyc[i] = 0;
      forever begin
         @(negedge clk);
         got_cyc[i]++;
         if (idx == 0 && (m0_ack || m0_err)) begin
            got_resp[i] = m0_err ? RESP_ERR : RESP_OK;
            got_data[i] = m0_dat_r;
            break;
         end
         if (idx == 1 && (m1_ack || m1_err)) begin
            got_resp[i] = m1_err ? RESP_ERR : RESP_OK;
            got_data[i] = m1_dat_r;
            break;
         end
      end
      @(negedge clk);                 // hold through the edge that ends the cycle.
      m_cyc[idx] = 1'b0;
      m_stb[idx] = 1'b0;
      order_q.push_back(idx);
   endtask

   task automatic finish_line(input int i, input int err_before);
      check_resp(t_name[i], t_resp[i], got_resp[i]);
      if (t_we[i] == 0 && t_resp[i] == RESP_OK) begin
         check_data(t_name[i], t_rdat[i], got_data[i]);
      end
      // one grant cycle comes before the strobe.
      if (t_adr[i][15:14] == 2'b01 && t_adr[i][7:0] == 8'hff && got_cyc[i] <= `WB_TIMEOUT) begin
         $display("%s: error arrived after %0d cycles, before the timeout", t_name[i],
                  got_cyc[i]);
         errors++;
      end
      tests++;
      $display("test %s %s", t_name[i], (errors == err_before) ? "ok" : "failed");
   endtask

   task automatic read_stimulus();
      int fd, m, p, w;
      string line, nm, rs;
      logic [`WB_ADR_W-1:0] a;
      logic [`WB_DAT_W-1:0] d, rd;
      fd = $fopen("dv/wb_stimulus.txt", "r");
      if (fd == 0) begin
         $display("cannot open the stimulus file");
         errors++;
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#" &&
                $sscanf(line, "%s %d %d %d %h %h %s %h", nm, m, p, w, a, d, rs, rd) == 8) begin
               t_name.push_back(nm);
               t_mst.push_back(m);
               t_pair.push_back(p);
               t_we.push_back(w);
               t_adr.push_back(a);
               t_wdat.push_back(d);
               t_resp.push_back(rs == "ERR" ? RESP_ERR : RESP_OK);
               t_rdat.push_back(rd);
            end
         end
         $fclose(fd);
         if (t_name.size() == 0) begin
            $display("stimulus file holds no tests");
            errors++;
         end
      end
   endtask

   initial begin
      int i, eb, winner;
      clk = 1'b0;
      rst_n = 1'b0;
      for (int k = 0; k < 2; k++) begin
         m_cyc[k] = 1'b0;
         m_stb[k] = 1'b0;
         m_we[k] = 1'b0;
         m_adr[k] = '0;
         m_dat_w[k] = '0;
      end
      read_stimulus();
      cyc_limit = t_name.size() * (`WB_TIMEOUT + 8) + 100;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      eb = errors;
      check_level("reset_m0_ack", 1'b0, m0_ack);
      check_level("reset_m0_err", 1'b0, m0_err);
      check_level("reset_m1_ack", 1'b0, m1_ack);
      check_level("reset_m1_err", 1'b0, m1_err);
      check_level("reset_s0_stb", 1'b0, s0_stb);
      check_level("reset_s1_stb", 1'b0, s1_stb);
      check_level("reset_s0_cyc", 1'b0, s0_cyc);
      check_level("reset_s1_cyc", 1'b0, s1_cyc);
      tests++;
      $display("test reset_idle %s", (errors == eb) ? "ok" : "failed");
      i = 0;
      while (i < t_name.size()) begin
         order_q.delete();
         eb = errors;
         if (t_pair[i] != 0 && i + 1 < t_name.size()) begin
            fork
               run_txn(i);
               run_txn(i + 1);
            join
            winner = 1 - last_served;          // round-robin pick.
            check_master(t_name[i], winner, order_q[0]);
            last_served = 1 - winner;
            finish_line(i, eb);
            finish_line(i + 1, errors);
            i += 2;
         end else begin
            run_txn(i);
            last_served = t_mst[i];
            finish_line(i, eb);
            i++;
         end
         repeat (2) @(negedge clk);            // let the arbiter release.
      end
      $display("tests %0d, errors %0d", tests, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end
endmodule : wb_conmax_tb_top

/* sources.f */
+incdir+include
design/wb_pkg.sv
design/wb_bus_if.sv
design/wb_arbiter_fsm.sv
design/wb_ack_timer.sv
design/wb_master_mux.sv
design/wb_slave_decoder.sv
design/wb_conmax_lite.sv
dv/wb_conmax_tb_top.sv

/* Makefile */
# Verilator build and run of the wb_conmax_lite testbench.

SIM := obj_dir/Vwb_conmax_tb_top

.PHONY: all run clean

all: run

$(SIM): sources.f include/wb_cfg.svh $(wildcard design/*.sv) $(wildcard dv/*.sv)
	verilator --binary --timing --assert --top-module wb_conmax_tb_top \
		-f sources.f -o Vwb_conmax_tb_top

run: $(SIM) dv/wb_stimulus.txt
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* dv/wb_stimulus.txt */
# name master pair we adr(hex) wdata(hex) resp rdata(hex)
# pair=1 starts this line together with the next line on the other master.
wr_s0_m0     0 0 1 0010 11112222 OK  00000000
rd_s0_m0     0 0 0 0010 00000000 OK  11112222
wr_s1_m1     1 0 1 4020 33334444 OK  00000000
rd_s1_m1     1 0 0 4020 00000000 OK  33334444
wr_s0_m1     1 0 1 0033 5a5a0033 OK  00000000
rd_s0_m0_x   0 0 0 0033 00000000 OK  5a5a0033
wr_s1_m0     0 0 1 40fe cafe00fe OK  00000000
rd_s1_m1_x   1 0 0 40fe 00000000 OK  cafe00fe
unmapped_rd  0 0 0 8000 00000000 ERR 00000000
unmapped_wr  1 0 1 c123 deadbeef ERR 00000000
silent_rd    0 0 0 40ff 00000000 ERR 00000000
silent_wr    1 0 1 40ff 12345678 ERR 00000000
pair1_wr_m0  0 1 1 0040 aaaa0040 OK  00000000
pair1_wr_m1  1 0 1 4040 bbbb4040 OK  00000000
pair2_rd_m0  0 1 0 0040 00000000 OK  aaaa0040
pair2_rd_m1  1 0 0 4040 00000000 OK  bbbb4040
pair3_rd_m0  0 1 0 4040 00000000 OK  bbbb4040
pair3_rd_m1  1 0 0 0040 00000000 OK  aaaa0040
pair4_wr_m1  1 1 1 0050 0f0f0050 OK  00000000
pair4_rd_m0  0 0 0 0010 00000000 OK  11112222
rd_s0_final  1 0 0 0050 00000000 OK  0f0f0050
